/* hw/plat_pkg.sv */
/*
 * Shared sizes and encodings for the accelerator platform.
 * One memory bank of 256 words; addresses wrap modulo MEM_DEPTH.
 * Burst lengths run from 0 to 16, and the fourth opcode is reserved.
 */
package plat_pkg;

    // Word address into the single local memory bank
    localparam int ADDR_W = 8;

    // Number of words in the bank, which must match 2**ADDR_W
    localparam int MEM_DEPTH = 256;

    // Width of a memory word and of the Sum result
    localparam int DATA_W = 32;

    // Burst length field, wide enough to hold 16
    localparam int LEN_W = 5;

    // Host opcodes; 2'b11 is left unassigned and completes like a zero length
    typedef enum logic [1:0] {
        OP_FILL = 2'b00,
        OP_COPY = 2'b01,
        OP_SUM  = 2'b10
    } afu_op_e;

    // AFU controller states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_READ  = 3'd1,
        ST_WAIT  = 3'd2,
        ST_WRITE = 3'd3,
        ST_ACK   = 3'd4,
        ST_DRAIN = 3'd5
    } afu_state_e;

endpackage

/* hw/local_mem_if.sv */
/*
 * Single-port local memory bus between the AFU and the bank model.
 * read and write are one-cycle pulses and never high together.
 * rvalid follows a read by exactly one cycle.
 */
`timescale 1ns/100ps

interface local_mem_if;

    // Request side, driven by the AFU
    logic [plat_pkg::ADDR_W-1:0] addr;
    logic [plat_pkg::DATA_W-1:0] wdata;
    logic                        write;
    logic                        read;

    // Response side, driven by the memory model
    logic [plat_pkg::DATA_W-1:0] rdata;
    logic                        rvalid;

    modport afu (
        output addr,
        output wdata,
        output write,
        output read,
        input  rdata,
        input  rvalid
    );

    modport mem (
        input  addr,
        input  wdata,
        input  write,
        input  read,
        output rdata,
        output rvalid
    );

endinterface

/* hw/local_mem_bank.sv */
/*
 * Local memory bank model with a one-cycle read latency.
 * The array has no reset, so words must be written before they are read.
 * A write lands on its clock edge and is visible to a read one cycle later.
 */
`timescale 1ns/100ps

module local_mem_bank
(
    input  logic      pClk,
    input  logic      rst_n,
    local_mem_if.mem  mem
);

    // Storage for the whole bank
    logic [plat_pkg::DATA_W-1:0] mem_array [plat_pkg::MEM_DEPTH];

    // Write port and registered read data
    always_ff @(posedge pClk)
    begin
        if (mem.write)
        begin
            mem_array[mem.addr] <= mem.wdata;
        end

        // Read data is captured only on a read so it holds between accesses
        if (mem.read)
        begin
            mem.rdata <= mem_array[mem.addr];
        end
    end

    // The response strobe trails the read request by one cycle
    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem.rvalid <= 1'b0;
        end
        else
        begin
            mem.rvalid <= mem.read;
        end
    end

endmodule

/* hw/burst_counter.sv */
/*
 * Word counter for one burst.
 * offset is 0 in the cycle after load and advances once per step.
 * last is only meaningful for a nonzero loaded length.
 */
`timescale 1ns/100ps

module burst_counter
(
    input  logic                       pClk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic [plat_pkg::LEN_W-1:0] len,
    input  logic                       step,
    output logic [plat_pkg::LEN_W-1:0] offset,
    output logic                       last
);

    // Length of the burst in flight
    logic [plat_pkg::LEN_W-1:0] len_q;

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            len_q  <= '0;
            offset <= '0;
        end
        else if (load)
        begin
            // A new burst restarts from word 0
            len_q  <= len;
            offset <= '0;
        end
        else if (step)
        begin
            offset <= offset + 1'b1;
        end
    end

    // Final word of the burst
    // With a zero length the compare never matches, so the AFU skips the burst
    assign last = (offset == len_q - 1'b1);

endmodule

/* hw/afu_ctrl.sv */
/*
 * AFU command engine: Fill, Copy and Sum over one local memory bank.
 * Host fields must stay stable while cmd_req is high; one command at a time.
 * Zero lengths and the reserved opcode acknowledge at once with rsp_data 0.
 */
`timescale 1ns/100ps

module afu_ctrl
(
    input  logic                        pClk,
    input  logic                        rst_n,
    input  logic                        cmd_req,
    input  plat_pkg::afu_op_e           cmd_op,
    input  logic [plat_pkg::ADDR_W-1:0] cmd_src,
    input  logic [plat_pkg::ADDR_W-1:0] cmd_dst,
    input  logic [plat_pkg::LEN_W-1:0]  cmd_len,
    input  logic [plat_pkg::DATA_W-1:0] cmd_data,
    output logic                        cmd_ack,
    output logic [plat_pkg::DATA_W-1:0] rsp_data,
    output logic                        load,
    output logic                        step,
    input  logic [plat_pkg::LEN_W-1:0]  offset,
    input  logic                        last,
    local_mem_if.afu                    mem
);

    plat_pkg::afu_state_e state;
    plat_pkg::afu_state_e state_next;

    // Captured command
    plat_pkg::afu_op_e           op_q;
    logic [plat_pkg::ADDR_W-1:0] src_q;
    logic [plat_pkg::ADDR_W-1:0] dst_q;

    // Write data holds the Fill word, or the word just read during a Copy
    logic [plat_pkg::DATA_W-1:0] wdata_q;
    logic [plat_pkg::DATA_W-1:0] acc_q;
    logic [plat_pkg::DATA_W-1:0] acc_sum;

    // Burst offset widened to an address
    logic [plat_pkg::ADDR_W-1:0] offset_addr;

    // Command with nothing to do
    logic                        cmd_empty;

    assign offset_addr = {{(plat_pkg::ADDR_W - plat_pkg::LEN_W){1'b0}}, offset};
    assign acc_sum     = acc_q + mem.rdata;

    assign cmd_empty = (cmd_len == '0) ||
                       ((cmd_op != plat_pkg::OP_FILL) &&
                        (cmd_op != plat_pkg::OP_COPY) &&
                        (cmd_op != plat_pkg::OP_SUM));

    // Counter is loaded as the command is accepted, so offset is 0 next cycle
    assign load = (state == plat_pkg::ST_IDLE) && cmd_req;

    // One step per finished word: each write, or each returned Sum word
    assign step = (state == plat_pkg::ST_WRITE) ||
                  ((state == plat_pkg::ST_WAIT) && mem.rvalid &&
                   (op_q == plat_pkg::OP_SUM));

    assign cmd_ack = (state == plat_pkg::ST_ACK);

    always_comb
    begin
        state_next = state;
        case (state)
            plat_pkg::ST_IDLE:
            begin
                if (cmd_req)
                begin
                    if (cmd_empty)
                        state_next = plat_pkg::ST_ACK;
                    else if (cmd_op == plat_pkg::OP_FILL)
                        state_next = plat_pkg::ST_WRITE;
                    else
                        state_next = plat_pkg::ST_READ;
                end
            end
            plat_pkg::ST_READ:
            begin
                state_next = plat_pkg::ST_WAIT;
            end
            plat_pkg::ST_WAIT:
            begin
                // Hold here until the bank returns the word
                if (mem.rvalid)
                begin
                    if (op_q == plat_pkg::OP_COPY)
                        state_next = plat_pkg::ST_WRITE;
                    else if (last)
                        state_next = plat_pkg::ST_ACK;
                    else
                        state_next = plat_pkg::ST_READ;
                end
            end
            plat_pkg::ST_WRITE:
            begin
                if (last)
                    state_next = plat_pkg::ST_ACK;
                else if (op_q == plat_pkg::OP_FILL)
                    state_next = plat_pkg::ST_WRITE;
                else
                    state_next = plat_pkg::ST_READ;
            end
            plat_pkg::ST_ACK:
            begin
                // The host may hold cmd_req as long as it likes
                if (!cmd_req)
                    state_next = plat_pkg::ST_DRAIN;
            end
            plat_pkg::ST_DRAIN:
            begin
                if (!cmd_req)
                    state_next = plat_pkg::ST_IDLE;
            end
            default:
            begin
                state_next = plat_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= plat_pkg::ST_IDLE;
            rsp_data <= '0;
        end
        else
        begin
            state <= state_next;
            // Fill, Copy and empty commands answer 0
            if (load)
                rsp_data <= '0;
            else if (step && (state == plat_pkg::ST_WAIT) && last)
                rsp_data <= acc_sum;
        end
    end

    always_ff @(posedge pClk)
    begin
        if (load)
        begin
            op_q    <= cmd_op;
            src_q   <= cmd_src;
            dst_q   <= cmd_dst;
            wdata_q <= cmd_data;
            acc_q   <= '0;
        end
        else if ((state == plat_pkg::ST_WAIT) && mem.rvalid)
        begin
            if (op_q == plat_pkg::OP_COPY)
                wdata_q <= mem.rdata;
            else
                acc_q <= acc_sum;
        end
    end

    // Memory requests decode straight from the state
    always_comb
    begin
        mem.read  = (state == plat_pkg::ST_READ);
        mem.write = (state == plat_pkg::ST_WRITE);
        mem.wdata = wdata_q;
        // Address arithmetic wraps at the top of the bank
        if (state == plat_pkg::ST_WRITE)
            mem.addr = dst_q + offset_addr;
        else
            mem.addr = src_q + offset_addr;
    end

endmodule

/* hw/plat_top.sv */
/*
 * Platform top: host command port, one AFU and one local memory bank.
 * Single clock domain on pClk; no cycles are added between the blocks.
 */
`timescale 1ns/100ps

module plat_top
(
    input  logic                        pClk,
    input  logic                        rst_n,
    input  logic                        cmd_req,
    input  plat_pkg::afu_op_e           cmd_op,
    input  logic [plat_pkg::ADDR_W-1:0] cmd_src,
    input  logic [plat_pkg::ADDR_W-1:0] cmd_dst,
    input  logic [plat_pkg::LEN_W-1:0]  cmd_len,
    input  logic [plat_pkg::DATA_W-1:0] cmd_data,
    output logic                        cmd_ack,
    output logic [plat_pkg::DATA_W-1:0] rsp_data
);

    // One memory bus, shared by the AFU and the bank model
    local_mem_if mem_bus();

    // Burst counter handshake
    logic                       load;
    logic                       step;
    logic [plat_pkg::LEN_W-1:0] offset;
    logic                       last;

    afu_ctrl u_afu
    (
        .pClk,
        .rst_n,
        .cmd_req,
        .cmd_op,
        .cmd_src,
        .cmd_dst,
        .cmd_len,
        .cmd_data,
        .cmd_ack,
        .rsp_data,
        .load,
        .step,
        .offset,
        .last,
        .mem      (mem_bus.afu)
    );

    // cmd_len is stable while cmd_req is high, so it is valid at load
    burst_counter u_burst
    (
        .pClk,
        .rst_n,
        .load,
        .len      (cmd_len),
        .step,
        .offset,
        .last
    );

    local_mem_bank u_bank
    (
        .pClk,
        .rst_n,
        .mem      (mem_bus.mem)
    );

endmodule

/* bench/plat_assert.sv */
/*
 * Host handshake and memory bus properties, bound to every afu_ctrl instance.
 * All properties are disabled while rst_n is low.
 */
`timescale 1ns/100ps

module plat_assert
(
    input  logic                        pClk,
    input  logic                        rst_n,
    input  logic                        cmd_req,
    input  logic                        cmd_ack,
    input  logic [plat_pkg::DATA_W-1:0] rsp_data,
    input  logic                        mem_read,
    input  logic                        mem_write
);

    // An acknowledge only ever answers a pending request
    ack_needs_req: assert property (@(posedge pClk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack rose while cmd_req was low");

    // The acknowledge is held for as long as the host holds its request
    ack_held: assert property (@(posedge pClk) disable iff (!rst_n)
        (cmd_ack && cmd_req) |=> cmd_ack)
        else $error("cmd_ack fell before cmd_req was released");

    // The response word must not move under a held acknowledge
    rsp_stable: assert property (@(posedge pClk) disable iff (!rst_n)
        (cmd_ack && $past(cmd_ack)) |-> $stable(rsp_data))
        else $error("rsp_data changed while cmd_ack was high");

    // Single-port bank, so one request kind per cycle
    one_access: assert property (@(posedge pClk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("read and write were requested in the same cycle");

endmodule

bind afu_ctrl plat_assert u_assert
(
    .pClk      (pClk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .rsp_data  (rsp_data),
    .mem_read  (mem.read),
    .mem_write (mem.write)
);

/* bench/plat_tb.sv */
/*
 * Testbench for plat_top that applies a command table through the four-phase handshake.
 * Expected responses come from a memory mirror updated as the table is built.
 * Every word read back is filled earlier in the table.
 */
`timescale 1ns/100ps

module plat_tb;

    localparam int MAX_ROWS = 64;

    logic                        pClk;
    logic                        rst_n;
    logic                        cmd_req;
    plat_pkg::afu_op_e           cmd_op;
    logic [plat_pkg::ADDR_W-1:0] cmd_src;
    logic [plat_pkg::ADDR_W-1:0] cmd_dst;
    logic [plat_pkg::LEN_W-1:0]  cmd_len;
    logic [plat_pkg::DATA_W-1:0] cmd_data;
    logic                        cmd_ack;
    logic [plat_pkg::DATA_W-1:0] rsp_data;

    // Command table, one entry per host command
    plat_pkg::afu_op_e           row_op   [MAX_ROWS];
    logic [plat_pkg::ADDR_W-1:0] row_src  [MAX_ROWS];
    logic [plat_pkg::ADDR_W-1:0] row_dst  [MAX_ROWS];
    logic [plat_pkg::LEN_W-1:0]  row_len  [MAX_ROWS];
    logic [plat_pkg::DATA_W-1:0] row_data [MAX_ROWS];
    logic [plat_pkg::DATA_W-1:0] row_exp  [MAX_ROWS];
    // Extra cycles the host keeps cmd_req high after cmd_ack
    int                          row_hold [MAX_ROWS];
    int                          row_count = 0;

    // Mirror of the bank contents as the table leaves them
    logic [plat_pkg::DATA_W-1:0] mirror [plat_pkg::MEM_DEPTH];
    logic [31:0]                 lfsr_q;
    int                          error_count = 0;
    int                          check_count = 0;
    int                          cycle_count = 0;
    int                          cycle_limit = 100;

    plat_top u_dut
    (
        .pClk, .rst_n, .cmd_req, .cmd_op, .cmd_src, .cmd_dst,
        .cmd_len, .cmd_data, .cmd_ack, .rsp_data
    );

    initial
    begin
        pClk = 1'b0;
        forever #5 pClk = ~pClk;
    end

    // Watchdog over the whole run
    always @(posedge pClk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the command handshake did not finish within %0d cycles",
                     cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit of the word
    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[30:0], lfsr_q[31]};
        end
    endtask

    function automatic logic [plat_pkg::ADDR_W-1:0] wrap_addr(input int base, input int k);
        int t;
        t = base + k;
        return t[plat_pkg::ADDR_W-1:0];
    endfunction

    // Appends a row and applies it to the mirror to get its expected response
    task automatic add_row(input plat_pkg::afu_op_e op, input int src, input int dst,
                           input int len, input logic [31:0] data, input int hold);
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < len; k++)
        begin
            case (op)
                plat_pkg::OP_FILL: mirror[wrap_addr(dst, k)] = data;
                plat_pkg::OP_COPY: mirror[wrap_addr(dst, k)] = mirror[wrap_addr(src, k)];
                default:           sum = sum + mirror[wrap_addr(src, k)];
            endcase
        end
        row_op[row_count]   = op;
        row_src[row_count]  = wrap_addr(src, 0);
        row_dst[row_count]  = wrap_addr(dst, 0);
        row_len[row_count]  = len[plat_pkg::LEN_W-1:0];
        row_data[row_count] = data;
        row_exp[row_count]  = (op == plat_pkg::OP_SUM) ? sum : 32'h0;
        row_hold[row_count] = hold;
        row_count           = row_count + 1;
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count = check_count + 1;
        assert (got === exp)
        else
        begin
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
            error_count = error_count + 1;
        end
    endtask

    // One full four-phase handshake for table row r
    task automatic run_row(input int r);
        @(posedge pClk);
        cmd_req  <= 1'b1;
        cmd_op   <= row_op[r];
        cmd_src  <= row_src[r];
        cmd_dst  <= row_dst[r];
        cmd_len  <= row_len[r];
        cmd_data <= row_data[r];
        do @(posedge pClk); while (cmd_ack !== 1'b1);
        check_word("rsp_data", rsp_data, row_exp[r]);
        // Back-pressure keeps the AFU parked in its acknowledge state
        for (int k = 0; k < row_hold[r]; k++)
        begin
            @(posedge pClk);
            check_count = check_count + 1;
            assert (cmd_ack === 1'b1)
            else
            begin
                $display("cmd_ack fell while row %0d still held cmd_req", r);
                error_count = error_count + 1;
            end
            check_word("rsp_data", rsp_data, row_exp[r]);
        end
        cmd_req <= 1'b0;
        do @(posedge pClk); while (cmd_ack !== 1'b0);
    endtask

    initial
    begin
        logic [31:0] w;
        rst_n    = 1'b0;
        cmd_req  = 1'b0;
        cmd_op   = plat_pkg::OP_FILL;
        cmd_src  = '0;
        cmd_dst  = '0;
        cmd_len  = '0;
        cmd_data = '0;
        lfsr_q   = 32'h3bc0;

        // Fill and read-back, the second run wraps from 255 to 0
        random_word(w);
        add_row(plat_pkg::OP_FILL, 0, 'h10, 8, w, 0);
        add_row(plat_pkg::OP_SUM, 'h10, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h13, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h17, 0, 1, 0, 0);
        random_word(w);
        add_row(plat_pkg::OP_FILL, 0, 'hfc, 8, w, 0);
        add_row(plat_pkg::OP_SUM, 'hfe, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'hff, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h00, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h03, 0, 1, 0, 0);

        // Distinct words, so a Copy that drops or shifts a word shows up
        for (int i = 0; i < 8; i++)
        begin
            random_word(w);
            add_row(plat_pkg::OP_FILL, 0, 'h20 + i, 1, w, 0);
        end
        add_row(plat_pkg::OP_COPY, 'h20, 'h60, 8, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h60, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h63, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h67, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h60, 0, 8, 0, 0);

        // Full-length Sum under back-pressure, then a plain read after release
        for (int i = 0; i < 16; i++)
        begin
            random_word(w);
            add_row(plat_pkg::OP_FILL, 0, 'h80 + i, 1, w, 0);
        end
        add_row(plat_pkg::OP_SUM, 'h80, 0, 16, 0, 5);
        add_row(plat_pkg::OP_SUM, 'h85, 0, 1, 0, 0);

        // This pair carries out of bit 31
        add_row(plat_pkg::OP_FILL, 0, 'h90, 1, 32'hffff_fff0, 0);
        add_row(plat_pkg::OP_FILL, 0, 'h91, 1, 32'h0000_0025, 0);
        add_row(plat_pkg::OP_SUM, 'h90, 0, 2, 0, 0);

        // Zero-length commands touch no memory word
        add_row(plat_pkg::OP_FILL, 0, 'h10, 0, 32'hdead_beef, 0);
        add_row(plat_pkg::OP_COPY, 'h80, 'h60, 0, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h10, 0, 0, 0, 2);
        add_row(plat_pkg::OP_SUM, 'h10, 0, 1, 0, 0);
        add_row(plat_pkg::OP_SUM, 'h60, 0, 1, 0, 0);

        cycle_limit = 64 * row_count + 100;

        repeat (3) @(posedge pClk);
        rst_n <= 1'b1;
        @(posedge pClk);
        check_word("cmd_ack", {31'b0, cmd_ack}, 32'h0);
        check_word("rsp_data", rsp_data, 32'h0);

        for (int r = 0; r < row_count; r++)
        begin
            run_row(r);
        end

        $display("Rows: %0d, checks: %0d, errors: %0d", row_count, check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* filelist.f */
hw/plat_pkg.sv
hw/local_mem_if.sv
hw/local_mem_bank.sv
hw/burst_counter.sv
hw/afu_ctrl.sv
hw/plat_top.sv
bench/plat_assert.sv
bench/plat_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the plat_tb simulation with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module plat_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vplat_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
